// ==== compile.f ====
common/rv_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
execute/alu_unit.sv
execute/lsu_unit.sv
logic/writeback_unit.sv
logic/rv_core_top.sv
dv/rv_core_asserts.sv
dv/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f compile.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb
	import rv_pkg::*;
;

	localparam xlen_t RESET_PC = 32'h0000_0100;
	localparam int NUM_REGS = 32;
	// seven programs of 50 instructions in all, about 8 cycles of reset and drain each
	localparam int MAX_CYCLES = 2 * (50 + 7 * 8);
	localparam xlen_t NOP = 32'h0000_0013;

	logic clk, reset;
	xlen_t i_pc_rddata, i_ldst_rddata, o_pc_addr, o_ldst_addr, o_ldst_wrdata;
	logic o_pc_rd, o_ldst_rd, o_ldst_wr;
	byte_en_t o_pc_byte_en, o_ldst_byte_en;
	xlen_t tb_regs [NUM_REGS];
	xlen_t imem [64];
	xlen_t dmem [256];
	xlen_t prog [$];
	int cycles = 0, checks = 0, errors = 0, tests = 0;

	rv_core_top #(.RESET_PC(RESET_PC), .NUM_REGS(NUM_REGS)) DUT (
		.clk(clk), .reset(reset), .o_pc_addr(o_pc_addr), .o_pc_rd(o_pc_rd),
		.o_pc_byte_en(o_pc_byte_en), .i_pc_rddata(i_pc_rddata),
		.o_ldst_addr(o_ldst_addr), .o_ldst_rd(o_ldst_rd), .o_ldst_wr(o_ldst_wr),
		.o_ldst_wrdata(o_ldst_wrdata), .o_ldst_byte_en(o_ldst_byte_en),
		.i_ldst_rddata(i_ldst_rddata), .o_tb_regs(tb_regs)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// memories answer one cycle after the strobe
	always @(posedge clk) begin
		if (o_pc_rd) begin
			// instruction reads always take all four lanes
			check_val("fetch byte enables", 32'h0000_000F, xlen_t'(o_pc_byte_en));
			i_pc_rddata <= imem[6'((o_pc_addr - RESET_PC) >> 2)];
		end
		if (o_ldst_rd) i_ldst_rddata <= dmem[o_ldst_addr[9:2]];
		if (o_ldst_wr) begin
			for (int b = 0; b < 4; b++) begin
				if (o_ldst_byte_en[b]) begin
					dmem[o_ldst_addr[9:2]][b*8 +: 8] <= o_ldst_wrdata[b*8 +: 8];
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic xlen_t enc_r(input logic [6:0] f7, input int rs2, rs1,
			input funct3_t f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'(OPC_OP)};
	endfunction

	function automatic xlen_t enc_i(input opcode_e opc, input logic [11:0] imm,
			input int rs1, input funct3_t f3, input int rd);
		return {imm, 5'(rs1), f3, 5'(rd), 7'(opc)};
	endfunction

	function automatic xlen_t enc_s(input logic [11:0] imm, input int rs2, rs1,
			input funct3_t f3);
		return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'(OPC_STORE)};
	endfunction

	function automatic xlen_t enc_u(input opcode_e opc, input logic [19:0] imm, input int rd);
		return {imm, 5'(rd), 7'(opc)};
	endfunction

	function automatic xlen_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// lui then addi with the upper part rounded for the sign of the low part
	task automatic put_const(input int rd, input xlen_t v);
		xlen_t up;
		up = v + 32'h800;
		prog.push_back(enc_u(OPC_LUI, up[31:12], rd));
		prog.push_back(enc_i(OPC_OP_IMM, v[11:0], rd, F3_ADD, rd));
	endtask

	task automatic check_val(input string name, input xlen_t exp, input xlen_t act);
		checks++;
		assert (exp === act) else begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests++;
		$display("%s: %s", name, (errors == errs_before) ? "ok" : "mismatch");
	endtask

	// load program, reset, run through the last write-back
	task automatic run_program();
		for (int i = 0; i < 64; i++) imem[i] = (i < prog.size()) ? prog[i] : NOP;
		for (int i = 0; i < 256; i++) dmem[i] = 32'hDA7A_0000 ^ (i * 32'h0001_0101);
		@(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (prog.size() + 4) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic test_r_type();
		int e0;
		xlen_t a, b;
		e0 = errors;
		a = $urandom();
		b = $urandom();
		prog.delete();
		put_const(1, a);
		put_const(2, b);
		prog.push_back(enc_r(7'h00, 2, 1, F3_ADD, 3));
		prog.push_back(enc_r(7'h20, 2, 1, F3_ADD, 4));
		prog.push_back(enc_r(7'h00, 2, 1, F3_XOR, 5));
		prog.push_back(enc_r(7'h00, 2, 1, F3_OR, 6));
		prog.push_back(enc_r(7'h00, 2, 1, F3_AND, 7));
		prog.push_back(enc_r(7'h00, 2, 1, F3_SLL, 8));
		prog.push_back(enc_r(7'h00, 2, 1, F3_SR, 9));
		prog.push_back(enc_r(7'h20, 2, 1, F3_SR, 10));
		prog.push_back(enc_r(7'h00, 2, 1, F3_SLT, 11));
		prog.push_back(enc_r(7'h00, 2, 1, F3_SLTU, 12));
		run_program();
		check_val("r_type add", a + b, tb_regs[3]);
		check_val("r_type sub", a - b, tb_regs[4]);
		check_val("r_type xor", a ^ b, tb_regs[5]);
		check_val("r_type or", a | b, tb_regs[6]);
		check_val("r_type and", a & b, tb_regs[7]);
		check_val("r_type sll", a << b[4:0], tb_regs[8]);
		check_val("r_type srl", a >> b[4:0], tb_regs[9]);
		check_val("r_type sra", xlen_t'($signed(a) >>> b[4:0]), tb_regs[10]);
		check_val("r_type slt", {31'b0, $signed(a) < $signed(b)}, tb_regs[11]);
		check_val("r_type sltu", {31'b0, a < b}, tb_regs[12]);
		report("r_type", e0);
	endtask

	task automatic test_i_type();
		int e0;
		xlen_t a;
		logic [11:0] imm;
		logic [4:0] sh;
		e0 = errors;
		a = $urandom();
		imm = 12'($urandom());
		sh = 5'($urandom());
		prog.delete();
		put_const(1, a);
		prog.push_back(enc_i(OPC_OP_IMM, imm, 1, F3_ADD, 3));
		prog.push_back(enc_i(OPC_OP_IMM, imm, 1, F3_XOR, 4));
		prog.push_back(enc_i(OPC_OP_IMM, imm, 1, F3_OR, 5));
		prog.push_back(enc_i(OPC_OP_IMM, imm, 1, F3_AND, 6));
		prog.push_back(enc_i(OPC_OP_IMM, {7'h00, sh}, 1, F3_SLL, 7));
		prog.push_back(enc_i(OPC_OP_IMM, {7'h00, sh}, 1, F3_SR, 8));
		prog.push_back(enc_i(OPC_OP_IMM, {7'h20, sh}, 1, F3_SR, 9));
		prog.push_back(enc_i(OPC_OP_IMM, 12'hFFB, 1, F3_SLT, 10));
		prog.push_back(enc_i(OPC_OP_IMM, 12'hFFB, 1, F3_SLTU, 11));
		run_program();
		check_val("i_type addi", a + sext12(imm), tb_regs[3]);
		check_val("i_type xori", a ^ sext12(imm), tb_regs[4]);
		check_val("i_type ori", a | sext12(imm), tb_regs[5]);
		check_val("i_type andi", a & sext12(imm), tb_regs[6]);
		check_val("i_type slli", a << sh, tb_regs[7]);
		check_val("i_type srli", a >> sh, tb_regs[8]);
		check_val("i_type srai", xlen_t'($signed(a) >>> sh), tb_regs[9]);
		check_val("i_type slti", {31'b0, $signed(a) < -5}, tb_regs[10]);
		check_val("i_type sltiu", {31'b0, a < 32'hFFFF_FFFB}, tb_regs[11]);
		report("i_type", e0);
	endtask

	task automatic test_bypass();
		int e0;
		xlen_t a, v2, v3, v4;
		e0 = errors;
		a = $urandom();
		prog.delete();
		put_const(1, a);
		prog.push_back(enc_i(OPC_OP_IMM, 12'd5, 1, F3_ADD, 2));
		prog.push_back(enc_r(7'h00, 1, 2, F3_ADD, 3));
		prog.push_back(enc_r(7'h20, 2, 3, F3_ADD, 4));
		prog.push_back(enc_r(7'h00, 3, 4, F3_XOR, 5));
		run_program();
		v2 = a + 5;
		v3 = v2 + a;
		v4 = v3 - v2;
		check_val("bypass addi", v2, tb_regs[2]);
		check_val("bypass add", v3, tb_regs[3]);
		check_val("bypass sub", v4, tb_regs[4]);
		check_val("bypass xor", v4 ^ v3, tb_regs[5]);
		report("bypass", e0);
	endtask

	task automatic test_upper();
		int e0;
		logic [19:0] u;
		e0 = errors;
		u = 20'($urandom());
		prog.delete();
		prog.push_back(NOP);
		prog.push_back(enc_u(OPC_LUI, u, 1));
		prog.push_back(enc_u(OPC_AUIPC, u, 2));
		run_program();
		check_val("upper lui", {u, 12'b0}, tb_regs[1]);
		check_val("upper auipc", RESET_PC + 32'd8 + {u, 12'b0}, tb_regs[2]);
		report("upper", e0);
	endtask

	task automatic test_load_store();
		int e0;
		xlen_t v, f17, f18;
		e0 = errors;
		v = $urandom();
		f17 = 32'hDA7A_0000 ^ (17 * 32'h0001_0101);
		f18 = 32'hDA7A_0000 ^ (18 * 32'h0001_0101);
		prog.delete();
		put_const(1, 32'h40);
		put_const(2, v);
		prog.push_back(enc_s(12'd0, 2, 1, F3_SW));
		prog.push_back(enc_s(12'd4, 2, 1, F3_SH));
		prog.push_back(enc_s(12'd8, 2, 1, F3_SB));
		prog.push_back(enc_i(OPC_LOAD, 12'd0, 1, F3_LW, 3));
		prog.push_back(enc_i(OPC_LOAD, 12'd8, 1, F3_LB, 4));
		prog.push_back(enc_i(OPC_LOAD, 12'd8, 1, F3_LBU, 5));
		prog.push_back(enc_i(OPC_LOAD, 12'd4, 1, F3_LH, 6));
		prog.push_back(enc_i(OPC_LOAD, 12'd4, 1, F3_LHU, 7));
		prog.push_back(enc_r(7'h00, 2, 7, F3_ADD, 8));
		run_program();
		check_val("ldst sw mem", v, dmem[16]);
		check_val("ldst sh mem", {f17[31:16], v[15:0]}, dmem[17]);
		check_val("ldst sb mem", {f18[31:8], v[7:0]}, dmem[18]);
		check_val("ldst lw", v, tb_regs[3]);
		check_val("ldst lb", {{24{v[7]}}, v[7:0]}, tb_regs[4]);
		check_val("ldst lbu", {24'b0, v[7:0]}, tb_regs[5]);
		check_val("ldst lh", {{16{v[15]}}, v[15:0]}, tb_regs[6]);
		check_val("ldst lhu", {16'b0, v[15:0]}, tb_regs[7]);
		check_val("ldst load use", {16'b0, v[15:0]} + v, tb_regs[8]);
		report("load_store", e0);
	endtask

	task automatic test_zero_reg();
		int e0;
		e0 = errors;
		prog.delete();
		run_program();
		for (int i = 0; i < NUM_REGS; i++) begin
			check_val($sformatf("zero reset x%0d", i), 0, tb_regs[i]);
		end
		prog.push_back(enc_i(OPC_OP_IMM, 12'd123, 0, F3_ADD, 0));
		prog.push_back(enc_u(OPC_LUI, 20'hABCDE, 0));
		prog.push_back(enc_i(OPC_OP_IMM, 12'd7, 0, F3_ADD, 1));
		run_program();
		check_val("zero x0", 0, tb_regs[0]);
		check_val("zero x1", 32'd7, tb_regs[1]);
		report("zero_reg", e0);
	endtask

	initial begin
		reset = 1'b1;
		i_pc_rddata = '0;
		i_ldst_rddata = '0;
		void'($urandom(32'h9709_3958));
		test_r_type();
		test_i_type();
		test_bypass();
		test_upper();
		test_load_store();
		test_zero_reg();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/rv_core_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_asserts (
	input wire        clk,
	input wire        reset,
	input wire [31:0] o_pc_addr,
	input wire        o_pc_rd,
	input wire        o_ldst_rd,
	input wire        o_ldst_wr
);

	// one data access per slot
	ldst_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(o_ldst_rd && o_ldst_wr)) else $error("data read and write strobes high together");

	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		o_pc_addr[1:0] == 2'b00) else $error("fetch address not word aligned");

	// strobe is cleared by the reset edge
	pc_rd_in_reset: assert property (@(posedge clk)
		reset |=> !o_pc_rd) else $error("instruction strobe high during reset");

endmodule

bind rv_core_top rv_core_asserts u_asserts (
	.clk(clk), .reset(reset), .o_pc_addr(o_pc_addr), .o_pc_rd(o_pc_rd),
	.o_ldst_rd(o_ldst_rd), .o_ldst_wr(o_ldst_wr)
);

`default_nettype wire

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_top
	import rv_pkg::*;
#(
	parameter xlen_t RESET_PC = 32'h0000_0000,
	parameter int    NUM_REGS = 32
)(
	input  wire        clk,
	input  wire        reset,
	output xlen_t      o_pc_addr,
	output logic       o_pc_rd,
	output byte_en_t   o_pc_byte_en,
	input  wire xlen_t i_pc_rddata,
	output xlen_t      o_ldst_addr,
	output logic       o_ldst_rd,
	output logic       o_ldst_wr,
	output xlen_t      o_ldst_wrdata,
	output byte_en_t   o_ldst_byte_en,
	input  wire xlen_t i_ldst_rddata,
	output xlen_t      o_tb_regs [NUM_REGS]
);

	logic      fetch_valid;
	xlen_t     fetch_pc;

	logic      dec_valid;
	opcode_e   dec_opcode;
	funct3_t   dec_funct3;
	logic      dec_alt;
	reg_addr_t dec_rs1;
	reg_addr_t dec_rs2;
	reg_addr_t dec_rd;
	xlen_t     dec_imm;
	xlen_t     dec_pc;

	xlen_t     rs1_data;
	xlen_t     rs2_data;

	logic      alu_valid;
	reg_addr_t alu_rd;
	xlen_t     alu_result;

	logic      load_valid;
	reg_addr_t load_rd;
	funct3_t   load_funct3;

	logic      wr_en;
	reg_addr_t wr_addr;
	xlen_t     wr_data;

	// instruction fetches are always full words
	assign o_pc_byte_en = '1;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk(clk), .reset(reset),
		.o_pc_addr(o_pc_addr), .o_pc_rd(o_pc_rd),
		.o_fetch_valid(fetch_valid), .o_fetch_pc(fetch_pc)
	);

	decode_unit u_decode (
		.clk(clk), .reset(reset),
		.i_fetch_valid(fetch_valid), .i_fetch_pc(fetch_pc), .i_instr(i_pc_rddata),
		.o_dec_valid(dec_valid), .o_opcode(dec_opcode), .o_funct3(dec_funct3),
		.o_alt(dec_alt), .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_rd(dec_rd),
		.o_imm(dec_imm), .o_pc(dec_pc)
	);

	reg_file #(
		.NUM_REGS(NUM_REGS)
	) u_regs (
		.clk(clk), .reset(reset),
		.i_rs1(dec_rs1), .i_rs2(dec_rs2),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_regs(o_tb_regs)
	);

	alu_unit u_alu (
		.clk(clk), .reset(reset),
		.i_dec_valid(dec_valid), .i_opcode(dec_opcode), .i_funct3(dec_funct3),
		.i_alt(dec_alt), .i_rd(dec_rd), .i_imm(dec_imm), .i_pc(dec_pc),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_alu_valid(alu_valid), .o_alu_rd(alu_rd), .o_alu_result(alu_result)
	);

	lsu_unit u_lsu (
		.clk(clk), .reset(reset),
		.i_dec_valid(dec_valid), .i_opcode(dec_opcode), .i_funct3(dec_funct3),
		.i_rd(dec_rd), .i_imm(dec_imm),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_ldst_addr(o_ldst_addr), .o_ldst_rd(o_ldst_rd), .o_ldst_wr(o_ldst_wr),
		.o_ldst_wrdata(o_ldst_wrdata), .o_ldst_byte_en(o_ldst_byte_en),
		.o_load_valid(load_valid), .o_load_rd(load_rd), .o_load_funct3(load_funct3)
	);

	writeback_unit u_writeback (
		.i_alu_valid(alu_valid), .i_alu_rd(alu_rd), .i_alu_result(alu_result),
		.i_load_valid(load_valid), .i_load_rd(load_rd), .i_load_funct3(load_funct3),
		.i_ldst_rddata(i_ldst_rddata),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
	);

endmodule

`default_nettype wire

// ==== logic/writeback_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_unit
	import rv_pkg::*;
(
	input  wire            i_alu_valid,
	input  wire reg_addr_t i_alu_rd,
	input  wire xlen_t     i_alu_result,
	input  wire            i_load_valid,
	input  wire reg_addr_t i_load_rd,
	input  wire funct3_t   i_load_funct3,
	input  wire xlen_t     i_ldst_rddata,
	output logic           o_wr_en,
	output reg_addr_t      o_wr_addr,
	output xlen_t          o_wr_data
);

	xlen_t load_value;

	// load data comes back in the low lanes
	always_comb begin
		case (i_load_funct3)
			F3_LB:   load_value = {{24{i_ldst_rddata[7]}}, i_ldst_rddata[7:0]};
			F3_LH:   load_value = {{16{i_ldst_rddata[15]}}, i_ldst_rddata[15:0]};
			F3_LW:   load_value = i_ldst_rddata;
			F3_LBU:  load_value = {24'b0, i_ldst_rddata[7:0]};
			F3_LHU:  load_value = {16'b0, i_ldst_rddata[15:0]};
			default: load_value = i_ldst_rddata;
		endcase
	end

	// only one of the two can be valid in a slot
	always_comb begin
		if (i_load_valid) begin
			o_wr_addr = i_load_rd;
			o_wr_data = load_value;
		end else begin
			o_wr_addr = i_alu_rd;
			o_wr_data = i_alu_result;
		end
		o_wr_en = (i_load_valid || i_alu_valid) && (o_wr_addr != '0);
	end

endmodule

`default_nettype wire

// ==== execute/lsu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_unit
	import rv_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire            i_dec_valid,
	input  wire opcode_e   i_opcode,
	input  wire funct3_t   i_funct3,
	input  wire reg_addr_t i_rd,
	input  wire xlen_t     i_imm,
	input  wire xlen_t     i_rs1_data,
	input  wire xlen_t     i_rs2_data,
	output xlen_t          o_ldst_addr,
	output logic           o_ldst_rd,
	output logic           o_ldst_wr,
	output xlen_t          o_ldst_wrdata,
	output byte_en_t       o_ldst_byte_en,
	output logic           o_load_valid,
	output reg_addr_t      o_load_rd,
	output funct3_t        o_load_funct3
);

	assign o_ldst_addr = i_rs1_data + i_imm;
	assign o_ldst_rd = i_dec_valid && (i_opcode == OPC_LOAD);
	assign o_ldst_wr = i_dec_valid && (i_opcode == OPC_STORE);

	// low two funct3 bits give the width for loads and stores alike
	always_comb begin
		case (i_funct3[1:0])
			F3_SB[1:0]: begin
				o_ldst_byte_en = 4'b0001;
				o_ldst_wrdata = {24'b0, i_rs2_data[7:0]};
			end
			F3_SH[1:0]: begin
				o_ldst_byte_en = 4'b0011;
				o_ldst_wrdata = {16'b0, i_rs2_data[15:0]};
			end
			F3_SW[1:0]: begin
				o_ldst_byte_en = 4'b1111;
				o_ldst_wrdata = i_rs2_data;
			end
			default: begin
				o_ldst_byte_en = 4'b1111;
				o_ldst_wrdata = i_rs2_data;
			end
		endcase
	end

	// load tag lines up with read data next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			o_load_valid <= 1'b0;
		end else begin
			o_load_valid <= o_ldst_rd;
		end
	end

	always_ff @(posedge clk) begin
		o_load_rd <= i_rd;
		o_load_funct3 <= i_funct3;
	end

endmodule

`default_nettype wire

// ==== execute/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit
	import rv_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire            i_dec_valid,
	input  wire opcode_e   i_opcode,
	input  wire funct3_t   i_funct3,
	input  wire            i_alt,
	input  wire reg_addr_t i_rd,
	input  wire xlen_t     i_imm,
	input  wire xlen_t     i_pc,
	input  wire xlen_t     i_rs1_data,
	input  wire xlen_t     i_rs2_data,
	output logic           o_alu_valid,
	output reg_addr_t      o_alu_rd,
	output xlen_t          o_alu_result
);

	logic       is_reg_op;
	logic       claims;
	xlen_t      op_b;
	logic [4:0] shamt;
	xlen_t      result;

	assign is_reg_op = (i_opcode == OPC_OP);
	assign op_b = is_reg_op ? i_rs2_data : i_imm;
	assign shamt = op_b[4:0];

	assign claims = (i_opcode == OPC_OP) || (i_opcode == OPC_OP_IMM) ||
		(i_opcode == OPC_LUI) || (i_opcode == OPC_AUIPC);

	always_comb begin
		result = '0;
		if (i_opcode == OPC_LUI) begin
			result = i_imm;
		end else if (i_opcode == OPC_AUIPC) begin
			result = i_pc + i_imm;
		end else begin
			case (i_funct3)
				F3_ADD: begin
					// the alt bit is an immediate bit for addi
					if (is_reg_op && i_alt) begin
						result = i_rs1_data - op_b;
					end else begin
						result = i_rs1_data + op_b;
					end
				end
				F3_SLL:  result = i_rs1_data << shamt;
				F3_SLT:  result = {31'b0, $signed(i_rs1_data) < $signed(op_b)};
				F3_SLTU: result = {31'b0, i_rs1_data < op_b};
				F3_XOR:  result = i_rs1_data ^ op_b;
				F3_SR: begin
					if (i_alt) begin
						result = $signed(i_rs1_data) >>> shamt;
					end else begin
						result = i_rs1_data >> shamt;
					end
				end
				F3_OR:   result = i_rs1_data | op_b;
				default: result = i_rs1_data & op_b;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_alu_valid <= 1'b0;
		end else begin
			o_alu_valid <= i_dec_valid & claims;
		end
	end

	always_ff @(posedge clk) begin
		o_alu_rd <= i_rd;
		o_alu_result <= result;
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
	import rv_pkg::*;
#(
	parameter int NUM_REGS = 32
)(
	input  wire            clk,
	input  wire            reset,
	input  wire reg_addr_t i_rs1,
	input  wire reg_addr_t i_rs2,
	input  wire            i_wr_en,
	input  wire reg_addr_t i_wr_addr,
	input  wire xlen_t     i_wr_data,
	output xlen_t          o_rs1_data,
	output xlen_t          o_rs2_data,
	output xlen_t          o_regs [NUM_REGS]
);

	xlen_t regs [NUM_REGS];

	// x0 and indices past the implemented set read zero
	function automatic xlen_t read_port(input reg_addr_t addr);
		xlen_t data;
		data = '0;
		if (addr != '0 && 32'(addr) < NUM_REGS) begin
			if (i_wr_en && addr == i_wr_addr) begin
				// same-cycle write goes straight through
				data = i_wr_data;
			end else begin
				data = regs[addr];
			end
		end
		return data;
	endfunction

	always_comb begin
		o_rs1_data = read_port(i_rs1);
		o_rs2_data = read_port(i_rs2);
	end

	assign o_regs = regs;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && i_wr_addr != '0 && 32'(i_wr_addr) < NUM_REGS) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_unit
	import rv_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire        i_fetch_valid,
	input  wire xlen_t i_fetch_pc,
	input  wire xlen_t i_instr,
	output logic       o_dec_valid,
	output opcode_e    o_opcode,
	output funct3_t    o_funct3,
	output logic       o_alt,
	output reg_addr_t  o_rs1,
	output reg_addr_t  o_rs2,
	output reg_addr_t  o_rd,
	output xlen_t      o_imm,
	output xlen_t      o_pc
);

	logic [6:0] funct7;
	logic       known_op;
	xlen_t      imm;

	assign funct7 = i_instr[31:25];

	// immediate format follows the major opcode
	always_comb begin
		known_op = 1'b1;
		imm = '0;
		case (i_instr[6:0])
			OPC_OP: begin
				imm = '0;
			end
			OPC_OP_IMM, OPC_LOAD: begin
				imm = {{20{i_instr[31]}}, i_instr[31:20]};
			end
			OPC_STORE: begin
				imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			end
			OPC_LUI, OPC_AUIPC: begin
				imm = {i_instr[31:12], 12'b0};
			end
			default: begin
				// branches, jumps and system ops become bubbles
				known_op = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_dec_valid <= 1'b0;
		end else begin
			o_dec_valid <= i_fetch_valid & known_op;
		end
	end

	// decoded fields for execute
	always_ff @(posedge clk) begin
		o_opcode <= opcode_e'(i_instr[6:0]);
		o_funct3 <= i_instr[14:12];
		o_alt <= funct7[F7_ALT];
		o_rs1 <= i_instr[19:15];
		o_rs2 <= i_instr[24:20];
		o_rd <= i_instr[11:7];
		o_imm <= imm;
		o_pc <= i_fetch_pc;
	end

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
	import rv_pkg::*;
#(
	parameter xlen_t RESET_PC = 32'h0000_0000
)(
	input  wire        clk,
	input  wire        reset,
	output xlen_t      o_pc_addr,
	output logic       o_pc_rd,
	output logic       o_fetch_valid,
	output xlen_t      o_fetch_pc
);

	xlen_t pc_q;

	assign o_pc_addr = pc_q;

	// strobe starts one cycle out of reset, pc steps with every fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= RESET_PC;
			o_pc_rd <= 1'b0;
			o_fetch_valid <= 1'b0;
		end else begin
			o_pc_rd <= 1'b1;
			o_fetch_valid <= o_pc_rd;
			if (o_pc_rd) begin
				pc_q <= pc_q + INSTR_BYTES;
			end
		end
	end

	// pc of the word arriving on the instruction port
	always_ff @(posedge clk) begin
		o_fetch_pc <= pc_q;
	end

endmodule

`default_nettype wire

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	// one data or instruction word
	typedef logic [31:0] xlen_t;

	// register index
	typedef logic [4:0] reg_addr_t;

	// minor operation field
	typedef logic [2:0] funct3_t;

	// byte lanes of one memory access
	typedef logic [3:0] byte_en_t;

	// major opcodes handled by this core
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// alu funct3 codes, shared by register and immediate forms
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// load widths
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;

	// store widths
	localparam funct3_t F3_SB = 3'b000;
	localparam funct3_t F3_SH = 3'b001;
	localparam funct3_t F3_SW = 3'b010;

	// bit of funct7 that selects sub and sra/srai
	localparam int F7_ALT = 5;

	// pc step
	localparam xlen_t INSTR_BYTES = 32'd4;

endpackage

`default_nettype wire
